//--- design/mastermind_pkg.sv
package mastermind_pkg;

    // Board geometry
    localparam int PEGS        = 4;
    localparam int COLOUR_BITS = 3;

    // Guesses allowed per round unless the top level overrides it
    localparam int MAX_GUESSES_DEFAULT = 8;

    // One peg of eight colours
    typedef logic [COLOUR_BITS-1:0] colour_t;

    // Peg position within a row
    typedef logic [1:0] slot_t;

    // Slot 0 sits in the low bits and is entered first
    typedef colour_t [PEGS-1:0] peg_row_t;

    // Red or white count from 0 to PEGS
    typedef logic [2:0] peg_count_t;

    // Per-player score
    typedef logic [7:0] score_t;

endpackage

//--- design/game_ctrl_if.sv
interface game_ctrl_if import mastermind_pkg::*; ();

    logic       load_code;
    logic       load_guess;
    slot_t      slot;
    colour_t    peg;
    logic       score_start;
    logic       score_done;
    peg_count_t red;
    peg_count_t white;
    logic       round_over;   // Qualified by score_done

    modport ctrl (
        output load_code, load_guess, slot, peg, score_start,
        input  score_done, round_over
    );

    modport reg_port (
        input load_code, load_guess, slot, peg
    );

    modport scorer (
        input  score_start,
        output score_done, red, white
    );

    modport keeper (
        input  score_done, red,
        output round_over
    );

endinterface

//--- design/game_control.sv
module game_control import mastermind_pkg::*; (
    input  logic    clock,
    input  logic    resetn,
    input  colour_t peg_i,
    input  logic    peg_valid_i,
    output logic    peg_ready_o,
    game_ctrl_if.ctrl ctl
);

    typedef enum logic [1:0] {
        CODE_ENTRY,
        GUESS_ENTRY,
        SCORING
    } state_t;

    state_t state;
    slot_t  slot_q;
    logic   accept;
    logic   last_slot;

    // Ready in both entry states and held off while scoring
    assign peg_ready_o = (state != SCORING);
    assign accept      = peg_valid_i && peg_ready_o;
    assign last_slot   = (slot_q == slot_t'(PEGS - 1));

    assign ctl.load_code  = accept && (state == CODE_ENTRY);
    assign ctl.load_guess = accept && (state == GUESS_ENTRY);
    assign ctl.slot       = slot_q;
    assign ctl.peg        = peg_i;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state           <= CODE_ENTRY;
            slot_q          <= '0;
            ctl.score_start <= 1'b0;
        end else begin
            ctl.score_start <= 1'b0;

            if (accept) begin
                slot_q <= slot_q + 2'd1;   // Wraps to 0 after the last peg
            end

            case (state)
                CODE_ENTRY: begin
                    if (accept && last_slot) begin
                        state <= GUESS_ENTRY;
                    end
                end
                GUESS_ENTRY: begin
                    if (accept && last_slot) begin
                        state           <= SCORING;
                        ctl.score_start <= 1'b1;
                    end
                end
                SCORING: begin
                    // Round over means the other player now enters a code
                    if (ctl.score_done) begin
                        state <= ctl.round_over ? CODE_ENTRY : GUESS_ENTRY;
                    end
                end
                default: begin
                    state <= CODE_ENTRY;
                end
            endcase
        end
    end

    // Scorer result only expected while a guess is being scored
    done_in_scoring: assert property (
        @(posedge clock) disable iff (!resetn)
        ctl.score_done |-> (state == SCORING)
    );

endmodule

//--- design/peg_register.sv
module peg_register import mastermind_pkg::*; #(
    parameter bit IS_CODE = 1'b0
) (
    input  logic     clock,
    input  logic     resetn,
    game_ctrl_if.reg_port bus,
    output peg_row_t row_o
);

    logic load;

    // Code row or guess row
    assign load = IS_CODE ? bus.load_code : bus.load_guess;

    // One slot per accepted peg
    always_ff @(posedge clock) begin
        if (load) begin
            row_o[bus.slot] <= bus.peg;
        end
    end

    // Control only ever fills one row at a time
    one_row_loading: assert property (
        @(posedge clock) disable iff (!resetn)
        !(bus.load_code && bus.load_guess)
    );

endmodule

//--- design/peg_scorer.sv
module peg_scorer import mastermind_pkg::*; (
    input  logic     clock,
    input  logic     resetn,
    game_ctrl_if.scorer bus,
    input  peg_row_t code_i,
    input  peg_row_t guess_i
);

    logic            busy;
    slot_t           pos;        // Code position being walked
    logic [PEGS-1:0] exact;
    logic [PEGS-1:0] claimed;    // Guess positions already used
    logic [PEGS-1:0] exact_now;
    peg_count_t      red_now;
    peg_count_t      red_acc;
    peg_count_t      white_acc;
    logic            hit;
    slot_t           hit_idx;

    // Exact matches for the first cycle
    always_comb begin
        red_now = '0;
        for (int i = 0; i < PEGS; i++) begin
            exact_now[i] = (code_i[i] == guess_i[i]);
            red_now      = red_now + peg_count_t'(exact_now[i]);
        end
    end

    // Lowest free guess position with the colour at pos
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int j = PEGS - 1; j >= 0; j--) begin
            if (!claimed[j] && (guess_i[j] == code_i[pos])) begin
                hit     = 1'b1;
                hit_idx = slot_t'(j);
            end
        end
        if (exact[pos]) begin
            hit = 1'b0;   // Already counted as red
        end
    end

    always_ff @(posedge clock) begin
        if (bus.score_start) begin
            exact     <= exact_now;
            claimed   <= exact_now;
            red_acc   <= red_now;
            white_acc <= '0;
        end else if (busy && hit) begin
            claimed[hit_idx] <= 1'b1;
            white_acc        <= white_acc + 3'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            busy           <= 1'b0;
            pos            <= '0;
            bus.score_done <= 1'b0;
            bus.red        <= '0;
            bus.white      <= '0;
        end else begin
            bus.score_done <= 1'b0;
            if (bus.score_start) begin
                busy <= 1'b1;
                pos  <= '0;
            end else if (busy) begin
                pos <= pos + 2'd1;
                if (pos == slot_t'(PEGS - 1)) begin
                    busy           <= 1'b0;
                    bus.score_done <= 1'b1;
                    bus.red        <= red_acc;
                    bus.white      <= white_acc + peg_count_t'(hit);
                end
            end
        end
    end

    // Each guess peg scores at most once
    pegs_bounded: assert property (
        @(posedge clock) disable iff (!resetn)
        bus.score_done |-> ({1'b0, bus.red} + {1'b0, bus.white}) <= 4'(PEGS)
    );

endmodule

//--- design/score_keeper.sv
module score_keeper import mastermind_pkg::*; #(
    parameter int MAX_GUESSES = MAX_GUESSES_DEFAULT
) (
    input  logic   clock,
    input  logic   resetn,
    game_ctrl_if.keeper bus,
    output logic [$clog2(MAX_GUESSES + 1)-1:0] guess_count_o,
    output score_t score_one_o,
    output score_t score_two_o,
    output logic   setter_o
);

    localparam int CNT_W = $clog2(MAX_GUESSES + 1);

    logic solved;
    logic last_guess;

    assign solved     = (bus.red == peg_count_t'(PEGS));
    assign last_guess = (guess_count_o == CNT_W'(MAX_GUESSES - 1));

    // Seen by control in the same cycle as score_done
    assign bus.round_over = bus.score_done && (solved || last_guess);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            guess_count_o <= '0;
            score_one_o   <= '0;
            score_two_o   <= '0;
            setter_o      <= 1'b0;   // Player one sets first
        end else if (bus.score_done) begin
            // Setter earns a point per guess made against their code
            if (setter_o) begin
                score_two_o <= score_two_o + 8'd1;
            end else begin
                score_one_o <= score_one_o + 8'd1;
            end

            if (bus.round_over) begin
                guess_count_o <= '0;
                setter_o      <= !setter_o;
            end else begin
                guess_count_o <= guess_count_o + CNT_W'(1);
            end
        end
    end

endmodule

//--- design/mastermind_top.sv
module mastermind_top import mastermind_pkg::*; #(
    parameter int MAX_GUESSES = MAX_GUESSES_DEFAULT
) (
    input  logic       clock,
    input  logic       resetn,
    input  colour_t    peg_i,
    input  logic       peg_valid_i,
    output logic       peg_ready_o,
    output peg_count_t red_o,
    output peg_count_t white_o,
    output logic       result_valid_o,
    output logic [$clog2(MAX_GUESSES + 1)-1:0] guess_count_o,
    output score_t     score_one_o,
    output score_t     score_two_o,
    output logic       setter_o
);

    peg_row_t code_row;
    peg_row_t guess_row;

    game_ctrl_if ctl_bus ();

    game_control u_control (
        .clock       (clock),
        .resetn      (resetn),
        .peg_i       (peg_i),
        .peg_valid_i (peg_valid_i),
        .peg_ready_o (peg_ready_o),
        .ctl         (ctl_bus.ctrl)
    );

    peg_register #(.IS_CODE(1'b1)) code_reg (
        .clock  (clock),
        .resetn (resetn),
        .bus    (ctl_bus.reg_port),
        .row_o  (code_row)
    );

    peg_register #(.IS_CODE(1'b0)) guess_reg (
        .clock  (clock),
        .resetn (resetn),
        .bus    (ctl_bus.reg_port),
        .row_o  (guess_row)
    );

    peg_scorer u_scorer (
        .clock   (clock),
        .resetn  (resetn),
        .bus     (ctl_bus.scorer),
        .code_i  (code_row),
        .guess_i (guess_row)
    );

    score_keeper #(.MAX_GUESSES(MAX_GUESSES)) u_keeper (
        .clock         (clock),
        .resetn        (resetn),
        .bus           (ctl_bus.keeper),
        .guess_count_o (guess_count_o),
        .score_one_o   (score_one_o),
        .score_two_o   (score_two_o),
        .setter_o      (setter_o)
    );

    // Scorer registers hold until the next result
    assign red_o          = ctl_bus.red;
    assign white_o        = ctl_bus.white;
    assign result_valid_o = ctl_bus.score_done;

endmodule

//--- include/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// 32-bit Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// Standard rule where white is common colours minus red
function automatic void ref_score(input peg_row_t code, input peg_row_t guess,
                                  output peg_count_t red, output peg_count_t white);
    int r;
    int common;
    int nc;
    int ng;
    r      = 0;
    common = 0;
    for (int i = 0; i < PEGS; i++) begin
        if (code[i] == guess[i]) r++;
    end
    for (int c = 0; c < 2 ** COLOUR_BITS; c++) begin
        nc = 0;
        ng = 0;
        for (int i = 0; i < PEGS; i++) begin
            if (code[i] == colour_t'(c)) nc++;
            if (guess[i] == colour_t'(c)) ng++;
        end
        common += (nc < ng) ? nc : ng;
    end
    red   = peg_count_t'(r);
    white = peg_count_t'(common - r);
endfunction

task automatic check_count(input string name, input peg_count_t actual,
                           input peg_count_t expected);
    if (actual !== expected) begin
        $display("[FAIL] %0t %s actual=%0d expected=%0d", $time, name, actual, expected);
        $fatal(1);
    end
endtask

task automatic check_score(input string name, input score_t actual, input score_t expected);
    if (actual !== expected) begin
        $display("[FAIL] %0t %s actual=%0d expected=%0d", $time, name, actual, expected);
        $fatal(1);
    end
endtask

`endif

//--- sim/tb_mastermind.sv
module tb_mastermind import mastermind_pkg::*; ;
    timeunit 1ns;
    timeprecision 1ps;

    `include "tb_checks.svh"

    localparam int MAX_GUESSES    = 8;
    localparam int CNT_W          = $clog2(MAX_GUESSES + 1);
    localparam int TIMEOUT_CYCLES = 4000;   // About 1000 cycles of tests

    logic             clock;
    logic             resetn;
    colour_t          peg_i;
    logic             peg_valid_i;
    logic             peg_ready_o;
    peg_count_t       red_o;
    peg_count_t       white_o;
    logic             result_valid_o;
    logic [CNT_W-1:0] guess_count_o;
    score_t           score_one_o;
    score_t           score_two_o;
    logic             setter_o;

    logic [31:0] lfsr_state;
    int          cycle_count = 0;
    int          exp_count;    // Expected game state
    score_t      exp_one;
    score_t      exp_two;
    logic        exp_setter;
    logic        round_done;   // Last result ended the round

    mastermind_top #(.MAX_GUESSES(MAX_GUESSES)) u_dut (
        .clock          (clock),
        .resetn         (resetn),
        .peg_i          (peg_i),
        .peg_valid_i    (peg_valid_i),
        .peg_ready_o    (peg_ready_o),
        .red_o          (red_o),
        .white_o        (white_o),
        .result_valid_o (result_valid_o),
        .guess_count_o  (guess_count_o),
        .score_one_o    (score_one_o),
        .score_two_o    (score_two_o),
        .setter_o       (setter_o)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run exceeded the cycle limit of %0d", TIMEOUT_CYCLES);
            report_failure();
            $fatal(1);
        end
    end

    task automatic report_failure();
        $display("tests failed");
    endtask

    task automatic expect_count(input string name, input peg_count_t actual,
                                input peg_count_t expected);
        if (actual !== expected) report_failure();
        check_count(name, actual, expected);
    endtask

    task automatic expect_score(input string name, input score_t actual,
                                input score_t expected);
        if (actual !== expected) report_failure();
        check_score(name, actual, expected);
    endtask

    task automatic expect_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            report_failure();
            $display("[FAIL] %0t %s actual=%0b expected=%0b", $time, name, actual, expected);
            $fatal(1);
        end
    endtask

    // Three LFSR steps per colour
    function automatic colour_t random_colour();
        colour_t c;
        for (int b = 0; b < COLOUR_BITS; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            c[b]       = lfsr_state[0];
        end
        return c;
    endfunction

    function automatic peg_row_t random_row();
        peg_row_t row;
        for (int i = 0; i < PEGS; i++) row[i] = random_colour();
        return row;
    endfunction

    function automatic peg_row_t make_row(input colour_t a, input colour_t b,
                                          input colour_t c, input colour_t d);
        peg_row_t row;
        row[0] = a;   // First peg entered
        row[1] = b;
        row[2] = c;
        row[3] = d;
        return row;
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    // Holds the peg until a transfer edge and leaves valid high
    task automatic send_peg(input colour_t c);
        peg_i       = c;
        peg_valid_i = 1'b1;
        while (!peg_ready_o) next_cycle();
        next_cycle();
    endtask

    task automatic send_row(input peg_row_t row);
        for (int i = 0; i < PEGS; i++) send_peg(row[i]);
        peg_valid_i = 1'b0;
    endtask

    task automatic check_state();
        expect_score("guess_count_o", score_t'(guess_count_o), score_t'(exp_count));
        expect_score("score_one_o", score_one_o, exp_one);
        expect_score("score_two_o", score_two_o, exp_two);
        expect_flag("setter_o", setter_o, exp_setter);
    endtask

    // Called just after the edge that took the fourth guess peg
    task automatic await_result(input peg_row_t code, input peg_row_t guess);
        peg_count_t red;
        peg_count_t white;
        ref_score(code, guess, red, white);
        for (int k = 1; k <= 5; k++) begin
            next_cycle();
            expect_flag("peg_ready_o", peg_ready_o, 1'b0);
            expect_flag("result_valid_o", result_valid_o, k == 5);
        end
        expect_count("red_o", red_o, red);
        expect_count("white_o", white_o, white);
        round_done = (red == peg_count_t'(PEGS)) || (exp_count == MAX_GUESSES - 1);
        if (exp_setter) exp_two++;
        else exp_one++;
        if (round_done) begin
            exp_count  = 0;
            exp_setter = !exp_setter;
        end else begin
            exp_count++;
        end
        next_cycle();
        expect_flag("result_valid_o", result_valid_o, 1'b0);
        expect_flag("peg_ready_o", peg_ready_o, 1'b1);
        check_state();
    endtask

    task automatic play_guess(input peg_row_t code, input peg_row_t guess);
        send_row(guess);
        await_result(code, guess);
    endtask

    task automatic reset_state();
        expect_flag("peg_ready_o", peg_ready_o, 1'b1);
        expect_flag("result_valid_o", result_valid_o, 1'b0);
        expect_count("red_o", red_o, 3'd0);
        expect_count("white_o", white_o, 3'd0);
        check_state();
    endtask

    task automatic exact_match_round();
        peg_row_t code;
        code = make_row(3'd5, 3'd2, 3'd7, 3'd0);
        send_row(code);
        play_guess(code, code);
        expect_score("score_one_o", score_one_o, 8'd1);
        expect_flag("setter_o", setter_o, 1'b1);
    endtask

    task automatic repeated_colour_guesses();
        peg_row_t code;
        code = make_row(3'd1, 3'd1, 3'd2, 3'd3);
        send_row(code);
        play_guess(code, make_row(3'd1, 3'd2, 3'd1, 3'd4));
        play_guess(code, make_row(3'd3, 3'd3, 3'd3, 3'd3));
        play_guess(code, make_row(3'd2, 3'd3, 3'd1, 3'd1));   // All white
        play_guess(code, make_row(3'd3, 3'd2, 3'd1, 3'd1));   // All white
        play_guess(code, make_row(3'd1, 3'd3, 3'd3, 3'd3));   // Red pegs not reused as white
        play_guess(code, make_row(3'd1, 3'd1, 3'd1, 3'd1));
        play_guess(code, make_row(3'd4, 3'd5, 3'd6, 3'd7));
        play_guess(code, code);
    endtask

    task automatic random_rounds();
        peg_row_t code;
        repeat (20) begin
            code = random_row();
            send_row(code);
            play_guess(code, random_row());
            if (!round_done) play_guess(code, code);
        end
    endtask

    task automatic guess_limit_round();
        peg_row_t code;
        peg_row_t wrong;
        logic     setter_before;
        setter_before = exp_setter;
        code          = random_row();
        for (int i = 0; i < PEGS; i++) wrong[i] = code[i] + 3'd1;   // No red possible
        send_row(code);
        repeat (MAX_GUESSES) play_guess(code, wrong);
        expect_score("guess_count_o", score_t'(guess_count_o), 8'd0);
        expect_flag("setter_o", setter_o, !setter_before);
        code = random_row();
        send_row(code);
        play_guess(code, code);
    endtask

    task automatic held_peg_waits();
        peg_row_t code;
        peg_row_t first;
        peg_row_t second;
        code   = make_row(3'd0, 3'd1, 3'd2, 3'd3);
        first  = make_row(3'd4, 3'd4, 3'd4, 3'd4);
        second = make_row(3'd3, 3'd0, 3'd1, 3'd2);   // Shift-sensitive
        send_row(code);
        for (int i = 0; i < PEGS; i++) send_peg(first[i]);
        peg_i = second[0];   // Valid left high through scoring
        await_result(code, first);
        send_row(second);
        await_result(code, second);
        if (!round_done) play_guess(code, code);
    endtask

    initial begin
        resetn      = 1'b0;
        peg_i       = '0;
        peg_valid_i = 1'b0;
        lfsr_state  = 32'hec26fbc8;
        exp_count   = 0;
        exp_one     = '0;
        exp_two     = '0;
        exp_setter  = 1'b0;
        round_done  = 1'b0;
        repeat (4) @(posedge clock);
        #2;
        resetn = 1'b1;

        reset_state();
        exact_match_round();
        repeated_colour_guesses();
        random_rounds();
        guess_limit_round();
        held_peg_waits();

        $display("all tests passed");
        $finish;
    end

endmodule

//--- mastermind_top.f
+incdir+include
design/mastermind_pkg.sv
design/game_ctrl_if.sv
design/game_control.sv
design/peg_register.sv
design/peg_scorer.sv
design/score_keeper.sv
design/mastermind_top.sv
sim/tb_mastermind.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mastermind \
    -f mastermind_top.f -o tb_mastermind

output=$(./obj_dir/tb_mastermind || true)
echo "$output"

if grep -qxF "all tests passed" <<< "$output"; then
    exit 0
else
    exit 1
fi
